/* logic/add_node_seq.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// registered adder node, add or forward one operand
////////////////////////////////////////////////////////////

module add_node_seq
#(
	parameter int DATA_WIDTH = 16
)
(
	input  wire                      clk,
	input  wire                      rst,
	// control
	input  wire                      i_en,
	input  rn_op_pkg::node_op_t      i_op,
	// operands, low operand in the low half
	input  wire  [1:0]               i_valid,
	input  wire  [2*DATA_WIDTH-1:0]  i_data_bus,
	// result, one bit wider than an operand
	output logic                     o_valid,
	output logic [DATA_WIDTH:0]      o_data
);

	import rn_op_pkg::*;

	// operand split
	logic [DATA_WIDTH-1:0] opnd_lo;
	logic [DATA_WIDTH-1:0] opnd_hi;

	// full-width sum, carry kept in the top bit
	logic [DATA_WIDTH:0]   sum;

	// next values of the output register
	logic                  nxt_valid;
	logic [DATA_WIDTH:0]   nxt_data;

	assign opnd_lo = i_data_bus[0 +: DATA_WIDTH];
	assign opnd_hi = i_data_bus[DATA_WIDTH +: DATA_WIDTH];
	assign sum     = {1'b0, opnd_lo} + {1'b0, opnd_hi};

	// operation decode
	// result only when the operands it needs are valid
	always_comb
	begin
		nxt_valid = 1'b0;
		nxt_data  = '0;
		case (i_op)
			OP_ADD:
			begin
				// both sides needed
				if (&i_valid)
				begin
					nxt_valid = 1'b1;
					nxt_data  = sum;
				end
			end
			OP_PASS_LO:
			begin
				if (i_valid[0])
				begin
					nxt_valid = 1'b1;
					nxt_data  = {1'b0, opnd_lo};
				end
			end
			OP_PASS_HI:
			begin
				if (i_valid[1])
				begin
					nxt_valid = 1'b1;
					nxt_data  = {1'b0, opnd_hi};
				end
			end
			default:
			begin
				// OP_NONE, output stays invalid zero
				nxt_valid = 1'b0;
				nxt_data  = '0;
			end
		endcase
	end

	// output register
	always_ff @(posedge clk)
	begin
		if (rst || !i_en)
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else
		begin
			o_valid <= nxt_valid;
			o_data  <= nxt_data;
		end
	end

endmodule

`default_nettype wire

/* logic/mux_2x1_seq.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// registered 2:1 selector with valid gating
////////////////////////////////////////////////////////////

module mux_2x1_seq
#(
	parameter int DATA_WIDTH = 16
)
(
	input  wire                      clk,
	input  wire                      rst,
	// control
	input  wire                      i_en,
	input  rn_op_pkg::mux_sel_t      i_cmd,
	// two branches with the low branch in the low half
	input  wire  [1:0]               i_valid,
	input  wire  [2*DATA_WIDTH-1:0]  i_data_bus,
	// selected branch one cycle later
	output logic                     o_valid,
	output logic [DATA_WIDTH-1:0]    o_data_bus
);

	import rn_op_pkg::*;

	// next values of the output register
	logic                  nxt_valid;
	logic [DATA_WIDTH-1:0] nxt_data;

	// pick the commanded branch
	// chosen branch invalid gives invalid zero
	// other branch ignored
	always_comb
	begin
		nxt_valid = 1'b0;
		nxt_data  = '0;
		case (i_cmd)
			SEL_LO:
			begin
				if (i_valid[0])
				begin
					nxt_valid = 1'b1;
					nxt_data  = i_data_bus[0 +: DATA_WIDTH];
				end
			end
			SEL_HI:
			begin
				if (i_valid[1])
				begin
					nxt_valid = 1'b1;
					nxt_data  = i_data_bus[DATA_WIDTH +: DATA_WIDTH];
				end
			end
		endcase
	end

	// output register
	// disabled stage clears to zero
	always_ff @(posedge clk)
	begin
		if (rst || !i_en)
		begin
			o_valid    <= 1'b0;
			o_data_bus <= '0;
		end
		else
		begin
			o_valid    <= nxt_valid;
			o_data_bus <= nxt_data;
		end
	end

endmodule

`default_nettype wire

/* logic/reduce_net_top.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// reduction network boundary
////////////////////////////////////////////////////////////

// four lanes in, total and partial sum out
// both outputs two cycles after the operands
// one operand set per cycle, no stall

module reduce_net_top
#(
	parameter int DATA_WIDTH = 16
)
(
	input  wire                                     clk,
	input  wire                                     rst,
	// global enable and per-set command
	input  wire                                     i_en,
	input  rn_cfg_pkg::tree_cmd_t                   i_cmd,
	// operand lanes, lane 0 lowest
	input  wire  [rn_cfg_pkg::N_LANES-1:0]            i_valid,
	input  wire  [rn_cfg_pkg::N_LANES*DATA_WIDTH-1:0] i_data,
	// total
	output logic                                    o_sum_valid,
	output logic [DATA_WIDTH+1:0]                   o_sum,
	// selected level-one result
	output logic                                    o_part_valid,
	output logic [DATA_WIDTH:0]                     o_part
);

	// tree outputs
	logic                  sum_valid;
	logic [DATA_WIDTH+1:0] sum;
	logic                  part_valid;
	logic [DATA_WIDTH:0]   part;

	// command fields are split out inside the tree
	reduce_tree #(.DATA_WIDTH(DATA_WIDTH)) tree0 (
		.clk          (clk),
		.rst          (rst),
		.i_en         (i_en),
		.i_cmd        (i_cmd),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.o_sum_valid  (sum_valid),
		.o_sum        (sum),
		.o_part_valid (part_valid),
		.o_part       (part)
	);

	// outputs
	assign o_sum_valid  = sum_valid;
	assign o_sum        = sum;
	assign o_part_valid = part_valid;
	assign o_part       = part;

endmodule

`default_nettype wire

/* logic/reduce_tree.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// two-level reduction tree over four lanes
////////////////////////////////////////////////////////////

module reduce_tree
#(
	parameter int DATA_WIDTH = 16
)
(
	input  wire                                     clk,
	input  wire                                     rst,
	// control, sampled with the operands
	input  wire                                     i_en,
	input  rn_cfg_pkg::tree_cmd_t                   i_cmd,
	// lanes, lane 0 lowest
	input  wire  [rn_cfg_pkg::N_LANES-1:0]            i_valid,
	input  wire  [rn_cfg_pkg::N_LANES*DATA_WIDTH-1:0] i_data,
	// total from the root node
	output logic                                    o_sum_valid,
	output logic [DATA_WIDTH+1:0]                   o_sum,
	// one level-one result from the mux
	output logic                                    o_part_valid,
	output logic [DATA_WIDTH:0]                     o_part
);

	import rn_op_pkg::*;

	// level-one result width, and the total one bit above it
	localparam int L1_WIDTH  = DATA_WIDTH + 1;
	localparam int SUM_WIDTH = DATA_WIDTH + 2;

	// level-one results, node 0 in the low half
	logic [1:0]            l1_valid;
	logic [2*L1_WIDTH-1:0] l1_data;

	// level-two config, delayed one stage with its operand set
	logic                  en_q;
	node_op_t              root_op_q;
	mux_sel_t              part_sel_q;

	// root node output before the port
	logic [SUM_WIDTH-1:0]  root_data;

	////////////////////////////////////////////////////////////
	// level one
	////////////////////////////////////////////////////////////

	// lanes 0 and 1
	add_node_seq #(.DATA_WIDTH(DATA_WIDTH)) node0 (
		.clk        (clk),
		.rst        (rst),
		.i_en       (i_en),
		.i_op       (i_cmd.node0_op),
		.i_valid    (i_valid[1:0]),
		.i_data_bus (i_data[0 +: 2*DATA_WIDTH]),
		.o_valid    (l1_valid[0]),
		.o_data     (l1_data[0 +: L1_WIDTH])
	);

	// lanes 2 and 3
	add_node_seq #(.DATA_WIDTH(DATA_WIDTH)) node1 (
		.clk        (clk),
		.rst        (rst),
		.i_en       (i_en),
		.i_op       (i_cmd.node1_op),
		.i_valid    (i_valid[3:2]),
		.i_data_bus (i_data[2*DATA_WIDTH +: 2*DATA_WIDTH]),
		.o_valid    (l1_valid[1]),
		.o_data     (l1_data[L1_WIDTH +: L1_WIDTH])
	);

	// carry level-two fields and enable along with the level-one results
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			en_q       <= 1'b0;
			root_op_q  <= OP_NONE;
			part_sel_q <= SEL_LO;
		end
		else
		begin
			en_q       <= i_en;
			root_op_q  <= i_cmd.root_op;
			part_sel_q <= i_cmd.part_sel;
		end
	end

	////////////////////////////////////////////////////////////
	// level two
	////////////////////////////////////////////////////////////

	// root, node 0 low and node 1 high
	add_node_seq #(.DATA_WIDTH(L1_WIDTH)) root0 (
		.clk        (clk),
		.rst        (rst),
		.i_en       (en_q),
		.i_op       (root_op_q),
		.i_valid    (l1_valid),
		.i_data_bus (l1_data),
		.o_valid    (o_sum_valid),
		.o_data     (root_data)
	);

	// partial sum, same two branches
	mux_2x1_seq #(.DATA_WIDTH(L1_WIDTH)) part0 (
		.clk        (clk),
		.rst        (rst),
		.i_en       (en_q),
		.i_cmd      (part_sel_q),
		.i_valid    (l1_valid),
		.i_data_bus (l1_data),
		.o_valid    (o_part_valid),
		.o_data_bus (o_part)
	);

	assign o_sum = root_data;

endmodule

`default_nettype wire

/* logic/rn_cfg_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////
// shape and command word of the reduction tree
////////////////////////////////////////////////////////////

package rn_cfg_pkg;

	// number of operand lanes
	// fixed, the tree below is built for exactly four
	localparam int N_LANES = 4;

	// command word for one operand set
	// seven bits, msb first:
	//   [6:5] node0_op   lanes 0 and 1
	//   [4:3] node1_op   lanes 2 and 3
	//   [2:1] root_op    level two adder
	//   [0]   part_sel   partial-sum mux
	typedef struct packed
	{
		// level one
		rn_op_pkg::node_op_t node0_op;
		rn_op_pkg::node_op_t node1_op;
		// level two
		rn_op_pkg::node_op_t root_op;
		rn_op_pkg::mux_sel_t part_sel;
	} tree_cmd_t;

endpackage

`default_nettype wire

/* logic/rn_op_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////
// operation encodings for the reduction tree
////////////////////////////////////////////////////////////

package rn_op_pkg;

	// adder node operation
	// add needs both operands valid, a pass needs only its own
	typedef enum logic [1:0]
	{
		OP_NONE    = 2'b00,
		OP_ADD     = 2'b01,
		OP_PASS_LO = 2'b10,
		OP_PASS_HI = 2'b11
	} node_op_t;

	// mux branch select
	// low branch on 0, high branch on 1
	typedef enum logic
	{
		SEL_LO = 1'b0,
		SEL_HI = 1'b1
	} mux_sel_t;

endpackage

`default_nettype wire

/* test/reduce_net_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module reduce_net_tb;

	import rn_op_pkg::*;
	import rn_cfg_pkg::*;

	localparam int DATA_WIDTH   = 16;
	localparam int L1_WIDTH     = DATA_WIDTH + 1;
	localparam int SUM_WIDTH    = DATA_WIDTH + 2;
	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int N_STREAM     = 30;
	// sets per test, two drain cycles each
	localparam int RUN_CYCLES   = (RESET_CYCLES + 2) + 5 + 14 + 6 + 5 + (N_STREAM + 2);
	localparam int TIMEOUT_NS   = (RUN_CYCLES + 40) * CLK_PERIOD;

	// expected outputs of one operand set
	typedef struct packed
	{
		logic                 sum_valid;
		logic [SUM_WIDTH-1:0] sum;
		logic                 part_valid;
		logic [L1_WIDTH-1:0]  part;
	} result_t;

	logic                             clk;
	logic                             rst;
	logic                             i_en;
	tree_cmd_t                        i_cmd;
	logic [N_LANES-1:0]               i_valid;
	logic [N_LANES*DATA_WIDTH-1:0]    i_data;
	logic                             o_sum_valid;
	logic [SUM_WIDTH-1:0]             o_sum;
	logic                             o_part_valid;
	logic [L1_WIDTH-1:0]              o_part;

	// sets in flight, oldest at the front
	result_t exp_q[$];
	int      checks;
	int      errors;
	integer  seed;

	reduce_net_top #(.DATA_WIDTH(DATA_WIDTH)) dut0 (
		.clk          (clk),
		.rst          (rst),
		.i_en         (i_en),
		.i_cmd        (i_cmd),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.o_sum_valid  (o_sum_valid),
		.o_sum        (o_sum),
		.o_part_valid (o_part_valid),
		.o_part       (o_part)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// hang guard
	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, run stopped", TIMEOUT_NS);
		$display("tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// one node, result as {valid, data}
	function automatic logic [SUM_WIDTH:0] node_result(node_op_t op, logic v_lo, logic v_hi,
		logic [L1_WIDTH-1:0] lo, logic [L1_WIDTH-1:0] hi);
		logic                 ok;
		logic [SUM_WIDTH-1:0] val;
		ok  = 1'b0;
		val = '0;
		if (op == OP_ADD && v_lo && v_hi)
		begin
			ok  = 1'b1;
			val = {1'b0, lo} + {1'b0, hi};
		end
		else if (op == OP_PASS_LO && v_lo)
		begin
			ok  = 1'b1;
			val = {1'b0, lo};
		end
		else if (op == OP_PASS_HI && v_hi)
		begin
			ok  = 1'b1;
			val = {1'b0, hi};
		end
		return {ok, val};
	endfunction

	// whole tree for one set, disabled set gives all zero
	function automatic result_t model_set(logic [63:0] data, logic [3:0] valid, tree_cmd_t cmd,
		logic en);
		logic [SUM_WIDTH:0] n0;
		logic [SUM_WIDTH:0] n1;
		logic [SUM_WIDTH:0] rt;
		result_t            res;
		res = '0;
		if (en)
		begin
			n0 = node_result(cmd.node0_op, valid[0], valid[1], {1'b0, data[15:0]},
				{1'b0, data[31:16]});
			n1 = node_result(cmd.node1_op, valid[2], valid[3], {1'b0, data[47:32]},
				{1'b0, data[63:48]});
			rt = node_result(cmd.root_op, n0[SUM_WIDTH], n1[SUM_WIDTH], n0[L1_WIDTH-1:0],
				n1[L1_WIDTH-1:0]);
			res.sum_valid = rt[SUM_WIDTH];
			res.sum       = rt[SUM_WIDTH-1:0];
			// invalid node already carries zero data
			if (cmd.part_sel == SEL_HI)
			begin
				res.part_valid = n1[SUM_WIDTH];
				res.part       = n1[L1_WIDTH-1:0];
			end
			else
			begin
				res.part_valid = n0[SUM_WIDTH];
				res.part       = n0[L1_WIDTH-1:0];
			end
		end
		return res;
	endfunction

	function automatic tree_cmd_t make_cmd(node_op_t n0, node_op_t n1, node_op_t root,
		mux_sel_t sel);
		tree_cmd_t c;
		c.node0_op = n0;
		c.node1_op = n1;
		c.root_op  = root;
		c.part_sel = sel;
		return c;
	endfunction

	// lane 0 lowest
	function automatic logic [63:0] lanes(logic [15:0] l0, logic [15:0] l1, logic [15:0] l2,
		logic [15:0] l3);
		return {l3, l2, l1, l0};
	endfunction

	////////////////////////////////////////////////////////////
	// drive and check
	////////////////////////////////////////////////////////////

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// outputs at a falling edge belong to the set driven two falling edges before
	task automatic check_outputs();
		result_t exp;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("no expected result left to compare at %0t", $time);
		end
		else
		begin
			exp = exp_q.pop_front();
			compare("o_sum_valid", o_sum_valid, exp.sum_valid);
			compare("o_sum", o_sum, exp.sum);
			compare("o_part_valid", o_part_valid, exp.part_valid);
			compare("o_part", o_part, exp.part);
		end
	endtask

	task automatic apply_set(input logic [63:0] data, input logic [3:0] valid,
		input tree_cmd_t cmd, input logic en);
		@(negedge clk);
		check_outputs();
		i_data  = data;
		i_valid = valid;
		i_cmd   = cmd;
		i_en    = en;
		exp_q.push_back(model_set(data, valid, cmd, en));
	endtask

	// two empty sets push the last real ones out
	task automatic drain();
		repeat (2) apply_set('0, 4'b0000, make_cmd(OP_NONE, OP_NONE, OP_NONE, SEL_LO), 1'b1);
	endtask

	task automatic report_test(input string name, input int start);
		$display("%s finished, %0d errors", name, errors - start);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic check_reset();
		int start;
		start = errors;
		// busy inputs so reset must win over them
		rst     = 1'b1;
		i_en    = 1'b1;
		i_valid = 4'b1111;
		i_data  = lanes(16'hffff, 16'h1234, 16'h8000, 16'h0001);
		i_cmd   = make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_HI);
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			compare("o_sum_valid", o_sum_valid, 0);
			compare("o_sum", o_sum, 0);
			compare("o_part_valid", o_part_valid, 0);
			compare("o_part", o_part, 0);
		end
		rst     = 1'b0;
		i_valid = 4'b0000;
		i_data  = '0;
		i_cmd   = make_cmd(OP_NONE, OP_NONE, OP_NONE, SEL_LO);
		// cleared level two, then the idle set just driven
		exp_q.push_back('0);
		exp_q.push_back('0);
		drain();
		report_test("reset", start);
	endtask

	task automatic full_reduction();
		int start;
		start = errors;
		apply_set(lanes(16'h0001, 16'h0002, 16'h0003, 16'h0004), 4'b1111,
			make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_LO), 1'b1);
		// carry into the top bit of the total
		apply_set(lanes(16'hffff, 16'hffff, 16'hffff, 16'hffff), 4'b1111,
			make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_HI), 1'b1);
		apply_set(lanes(16'hffff, 16'h0001, 16'hfffe, 16'h8000), 4'b1111,
			make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_LO), 1'b1);
		drain();
		report_test("full reduction", start);
	endtask

	task automatic pass_modes();
		int       start;
		int       k;
		node_op_t op0;
		node_op_t op1;
		node_op_t opr;
		start = errors;
		// every pass combination over three nodes
		for (k = 0; k < 8; k++)
		begin
			op0 = k[0] ? OP_PASS_HI : OP_PASS_LO;
			op1 = k[1] ? OP_PASS_HI : OP_PASS_LO;
			opr = k[2] ? OP_PASS_HI : OP_PASS_LO;
			apply_set(lanes(16'h1100 + k, 16'h2200 + k, 16'h3300 + k, 16'h4400 + k), 4'b1111,
				make_cmd(op0, op1, opr, k[0] ? SEL_HI : SEL_LO), 1'b1);
		end
		// named lane invalid, or no operation
		apply_set(lanes(16'haaaa, 16'hbbbb, 16'hcccc, 16'hdddd), 4'b1110,
			make_cmd(OP_PASS_LO, OP_PASS_HI, OP_ADD, SEL_LO), 1'b1);
		apply_set(lanes(16'h0101, 16'h0202, 16'h0303, 16'h0404), 4'b1111,
			make_cmd(OP_NONE, OP_ADD, OP_PASS_HI, SEL_LO), 1'b1);
		apply_set(lanes(16'h1000, 16'h2000, 16'h3000, 16'h4000), 4'b1111,
			make_cmd(OP_ADD, OP_ADD, OP_NONE, SEL_HI), 1'b1);
		apply_set(lanes(16'h5555, 16'h6666, 16'h7777, 16'h8888), 4'b0111,
			make_cmd(OP_PASS_LO, OP_PASS_HI, OP_PASS_HI, SEL_HI), 1'b1);
		drain();
		report_test("pass modes", start);
	endtask

	task automatic partial_select();
		int start;
		start = errors;
		// only node 0 valid
		apply_set(lanes(16'h0010, 16'h0020, 16'h0030, 16'h0040), 4'b0011,
			make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_HI), 1'b1);
		apply_set(lanes(16'h0010, 16'h0020, 16'h0030, 16'h0040), 4'b0011,
			make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_LO), 1'b1);
		// only node 1 valid
		apply_set(lanes(16'h0500, 16'h0600, 16'h0700, 16'hf800), 4'b1100,
			make_cmd(OP_ADD, OP_ADD, OP_PASS_HI, SEL_LO), 1'b1);
		apply_set(lanes(16'h0500, 16'h0600, 16'h0700, 16'hf800), 4'b1100,
			make_cmd(OP_ADD, OP_ADD, OP_PASS_HI, SEL_HI), 1'b1);
		drain();
		report_test("partial select", start);
	endtask

	task automatic enable_gating();
		int start;
		start = errors;
		// middle set dropped, its neighbours intact
		apply_set(lanes(16'h0111, 16'h0222, 16'h0333, 16'h0444), 4'b1111,
			make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_HI), 1'b1);
		apply_set(lanes(16'h7777, 16'h7777, 16'h7777, 16'h7777), 4'b1111,
			make_cmd(OP_ADD, OP_ADD, OP_ADD, SEL_LO), 1'b0);
		apply_set(lanes(16'h0999, 16'h0888, 16'h0777, 16'h0666), 4'b1111,
			make_cmd(OP_ADD, OP_PASS_LO, OP_ADD, SEL_LO), 1'b1);
		drain();
		report_test("enable", start);
	endtask

	task automatic random_stream();
		int          start;
		int          k;
		logic [31:0] r;
		logic [63:0] data;
		tree_cmd_t   cmd;
		start = errors;
		for (k = 0; k < N_STREAM; k++)
		begin
			data = {$random(seed), $random(seed)};
			r    = $random(seed);
			cmd  = r[10:4];
			// lanes biased towards valid
			apply_set(data, r[3:0] | r[14:11], cmd, 1'b1);
		end
		drain();
		report_test("random stream", start);
	endtask

	initial
	begin
		rst     = 1'b1;
		i_en    = 1'b0;
		i_cmd   = '0;
		i_valid = '0;
		i_data  = '0;
		checks  = 0;
		errors  = 0;
		seed    = 71;
		check_reset();
		full_reduction();
		pass_modes();
		partial_select();
		enable_gating();
		random_stream();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
logic/rn_op_pkg.sv
logic/rn_cfg_pkg.sv
logic/mux_2x1_seq.sv
logic/add_node_seq.sv
logic/reduce_tree.sv
logic/reduce_net_top.sv
test/reduce_net_tb.sv
